/* build.f */
design/spi_pkg.sv
design/spi_master.sv
design/spi_crc8.sv
design/spi_frame_ctrl.sv
design/spi_crc_link.sv
test/spi_slave_model.sv
test/spi_crc_link_tb.sv

/* Makefile */
# Verilator build for the crc protected spi link

VERILATOR ?= verilator
TOP       ?= spi_crc_link_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/spi_crc_link_tb.sv */
// testbench for the crc protected spi link
// random frames against a behavioural slave
// expected crc computed bit by bit here
`timescale 1ns/1ps

module spi_crc_link_tb;
	import spi_pkg::*;

	logic		sys_clk;
	logic		sys_rst_n;
	div_t		clk_div_val;
	logic		frame_start;
	len_t		frame_len;
	byte_t		data_tx;
	logic		tx_next;
	logic		busy;
	logic		rx_valid;
	byte_t		rx_data;
	frame_status_t	status;
	spi_pins_t	pins;
	logic		miso;

	int		errors;
	int		tests_run;
	int		tests_failed;
	byte_t		payload[16];
	byte_t		reply[16];
	int		rx_cnt;			// rx_valid pulses this frame
	int		done_cnt;
	int		tx_gap;			// cycles since last tx_next
	logic		tx_seen;
	int		exp_gap;
	logic		prev_sclk;

	spi_crc_link #(.CPOL(1'b1), .CPHA(1'b1)) spi_crc_link_i (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .clk_div_val(clk_div_val),
		.frame_start(frame_start), .frame_len(frame_len), .data_tx(data_tx),
		.tx_next(tx_next), .busy(busy), .rx_valid(rx_valid), .rx_data(rx_data),
		.status(status), .pins(pins), .miso(miso)
	);

	spi_slave_model slave_i (.cs(pins.cs), .sclk(pins.sclk), .mosi(pins.mosi), .miso(miso));

	always #5 sys_clk = ~sys_clk;

	task automatic report_mismatch(input string name, input int exp, input int got);
		$display("mismatch t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
		errors++;
	endtask

	// bit serial crc-8, poly 0x07, msb first
	function automatic byte_t crc_of(input byte_t bytes[16], input int n);
		byte_t	r;
		logic	fb;
		r = 8'h00;
		for (int k = 0; k < n; k++) begin
			for (int b = 7; b >= 0; b--) begin
				fb = r[7] ^ bytes[k][b];
				r = {r[6:0], 1'b0};
				if (fb)
					r = r ^ 8'h07;
			end
		end
		return r;
	endfunction

	// chip select low only inside a busy frame
	cs_inside_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!pins.cs |-> busy)
		else begin
			$display("cs low while busy is low at t=%0t", $time);
			errors++;
		end

	// monitors sample pre-edge values
	always @(posedge sys_clk) begin
		prev_sclk <= pins.sclk;
		if (sys_rst_n && pins.sclk != prev_sclk)
			assert (!pins.cs) else begin
				$display("sclk toggled with cs high at t=%0t", $time);
				errors++;
			end
		if (frame_start && !busy) begin
			rx_cnt		<= 0;
			done_cnt	<= 0;
			tx_seen		<= 1'b0;
			tx_gap		<= 0;
		end else begin
			tx_gap <= tx_gap + 1;
			if (rx_valid) begin
				assert (rx_data == reply[rx_cnt])
					else report_mismatch("rx_data", reply[rx_cnt], rx_data);
				rx_cnt <= rx_cnt + 1;
			end
			if (status.done)
				done_cnt <= done_cnt + 1;
			if (tx_next) begin
				if (tx_seen)
					assert (tx_gap == exp_gap)
						else report_mismatch("tx_next gap", exp_gap, tx_gap);
				tx_seen	<= 1'b1;
				tx_gap	<= 1;
			end
		end
	end

	task automatic run_frame(input int len, input bit corrupt);
		int	idx;
		int	wait_cnt;
		int	err0;
		byte_t	div;
		byte_t	tx_crc;
		byte_t	rx_crc;
		err0	= errors;
		div	= byte_t'($urandom % 4);
		for (int k = 0; k < 16; k++) begin
			payload[k]	= byte_t'($urandom);
			reply[k]	= byte_t'($urandom);
		end
		tx_crc = crc_of(payload, len);
		rx_crc = crc_of(reply, len);
		slave_i.mosi_q.delete();
		slave_i.reply_q.delete();
		for (int k = 0; k < len; k++)
			slave_i.reply_q.push_back(reply[k]);
		slave_i.reply_q.push_back(corrupt ? rx_crc ^ (8'h01 << ($urandom % 8)) : rx_crc);
		exp_gap = 17 * div + 37;	// one cycle to the sampling edge plus ack latency plus two
		@(posedge sys_clk);
		clk_div_val	<= {8'h00, div};
		frame_len	<= len_t'(len);
		data_tx		<= payload[0];
		frame_start	<= 1'b1;
		idx		= 0;
		wait_cnt	= 0;
		forever begin
			@(posedge sys_clk);
			frame_start <= 1'b0;
			if (tx_next && idx < 15) begin
				idx++;
				data_tx <= payload[idx];
			end
			if (status.done) begin
				assert (status.crc_ok == !corrupt)
					else report_mismatch("status.crc_ok", !corrupt, status.crc_ok);
				break;
			end
			wait_cnt++;
			if (wait_cnt > 5000) begin
				$display("timeout waiting for status.done");
				errors++;
				break;
			end
		end
		wait_cnt = 0;
		while (busy && wait_cnt < 100) begin
			@(posedge sys_clk);
			wait_cnt++;
		end
		if (busy) begin
			$display("timeout waiting for busy to fall");
			errors++;
		end
		@(posedge sys_clk);
		assert (slave_i.mosi_q.size() == len + 1)
			else report_mismatch("mosi byte count", len + 1, slave_i.mosi_q.size());
		for (int k = 0; k < slave_i.mosi_q.size() && k <= len; k++)
			assert (slave_i.mosi_q[k] == (k == len ? tx_crc : payload[k]))
				else report_mismatch("mosi byte", k == len ? tx_crc : payload[k],
					slave_i.mosi_q[k]);
		assert (slave_i.edge_total == 16 * (len + 1))
			else report_mismatch("sclk edges", 16 * (len + 1), slave_i.edge_total);
		assert (rx_cnt == len) else report_mismatch("rx_valid count", len, rx_cnt);
		assert (done_cnt == 1) else report_mismatch("done count", 1, done_cnt);
		tests_run++;
		if (errors != err0)
			tests_failed++;
		$display("frame test %0d len=%0d div=%0d bad_crc=%0d: %s", tests_run, len, div,
			corrupt, (errors == err0) ? "ok" : "FAILED");
	endtask

	initial begin
		int	len;
		errors		= 0;
		tests_run	= 0;
		tests_failed	= 0;
		sys_clk		= 1'b0;
		sys_rst_n	= 1'b0;
		clk_div_val	= '0;
		frame_start	= 1'b0;
		frame_len	= '0;
		data_tx		= '0;
		void'($urandom(29));
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		// idle levels after reset
		assert (pins.cs == 1'b1) else report_mismatch("pins.cs", 1, pins.cs);
		assert (pins.sclk == 1'b1) else report_mismatch("pins.sclk", 1, pins.sclk);
		assert (!busy) else report_mismatch("busy", 0, busy);
		assert (!rx_valid) else report_mismatch("rx_valid", 0, rx_valid);
		assert (!tx_next) else report_mismatch("tx_next", 0, tx_next);
		assert (!status.done) else report_mismatch("status.done", 0, status.done);
		tests_run++;
		if (errors != 0)
			tests_failed++;
		$display("reset test: %s", (errors == 0) ? "ok" : "FAILED");
		for (int t = 0; t < 8; t++) begin
			if (t == 0)
				len = 1;
			else if (t == 1)
				len = 15;
			else
				len = 1 + ($urandom % 15);
			run_frame(len, t[0]);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* test/spi_slave_model.sv */
// behavioural spi slave, CPOL=1 CPHA=1
// records mosi bytes and shifts out a queued reply, counts sclk edges per frame
`timescale 1ns/1ps

module spi_slave_model (
	input  logic	cs,
	input  logic	sclk,
	input  logic	mosi,
	output logic	miso
);
	import spi_pkg::*;

	byte_t		reply_q[$];		// loaded by the testbench
	byte_t		mosi_q[$];		// bytes seen on mosi
	int		edge_total;		// sclk edges while selected
	logic [2:0]	drive_bit;
	logic [3:0]	rx_bits;
	byte_t		cur;			// byte being shifted out
	byte_t		rx_shift;

	initial begin
		miso		= 1'b0;
		edge_total	= 0;
		drive_bit	= '0;
		rx_bits		= '0;
		cur		= '0;
		rx_shift	= '0;
	end

	// new frame
	always @(negedge cs) begin
		edge_total	= 0;
		drive_bit	= '0;
		rx_bits		= '0;
	end

	always @(sclk) begin
		if (!cs)
			edge_total = edge_total + 1;
	end

	// leading edge, present the next bit
	always @(negedge sclk) begin
		if (!cs) begin
			if (drive_bit == 3'd0) begin
				if (reply_q.size() > 0)
					cur = reply_q.pop_front();
				else
					cur = 8'h00;	// nothing queued
			end
			miso		= cur[3'd7 - drive_bit];
			drive_bit	= drive_bit + 3'd1;
		end
	end

	// trailing edge, capture mosi
	always @(posedge sclk) begin
		if (!cs) begin
			rx_shift	= {rx_shift[6:0], mosi};
			rx_bits		= rx_bits + 4'd1;
			if (rx_bits == 4'd8) begin
				mosi_q.push_back(rx_shift);
				rx_bits = '0;
			end
		end
	end

endmodule

/* design/spi_crc_link.sv */
// crc protected spi link, top level
// bit engine, tx and rx crc units and the frame sequencer
`timescale 1ns/1ps

module spi_crc_link #(
	parameter logic CPOL = 1'b1,			// sclk idle level
	parameter logic CPHA = 1'b1			// sampling edge
) (
	input  logic			sys_clk,
	input  logic			sys_rst_n,
	input  spi_pkg::div_t		clk_div_val,
	input  logic			frame_start,
	input  spi_pkg::len_t		frame_len,
	input  spi_pkg::byte_t		data_tx,
	output logic			tx_next,
	output logic			busy,
	output logic			rx_valid,
	output spi_pkg::byte_t		rx_data,
	output spi_pkg::frame_status_t	status,
	output spi_pkg::spi_pins_t	pins,
	input  logic			miso
);
	import spi_pkg::*;

	logic		cs_ctrl;
	logic		wr_req;
	logic		wr_ack;
	byte_t		byte_out;		// payload or crc to the master
	byte_t		data_rx;
	logic		crc_clr;
	logic		tx_crc_upd;
	logic		rx_crc_upd;
	byte_t		tx_crc;
	byte_t		rx_crc;
	logic		bus_cs;
	logic		bus_sclk;
	logic		bus_mosi;

	assign pins.cs		= bus_cs;
	assign pins.sclk	= bus_sclk;
	assign pins.mosi	= bus_mosi;

	spi_master #(
		.CPOL		(CPOL),
		.CPHA		(CPHA)
	) master_i (
		.sys_clk	(sys_clk),
		.sys_rst_n	(sys_rst_n),
		.cs_ctrl	(cs_ctrl),
		.clk_div_val	(clk_div_val),
		.wr_req		(wr_req),
		.data_tx	(byte_out),
		.wr_ack		(wr_ack),
		.data_rx	(data_rx),
		.miso		(miso),
		.cs		(bus_cs),
		.sclk		(bus_sclk),
		.mosi		(bus_mosi)
	);

	// crc over sent payload
	spi_crc8 tx_crc_i (
		.sys_clk	(sys_clk),
		.sys_rst_n	(sys_rst_n),
		.clr		(crc_clr),
		.upd		(tx_crc_upd),
		.data		(byte_out),
		.crc		(tx_crc)
	);

	// crc over received payload
	spi_crc8 rx_crc_i (
		.sys_clk	(sys_clk),
		.sys_rst_n	(sys_rst_n),
		.clr		(crc_clr),
		.upd		(rx_crc_upd),
		.data		(data_rx),
		.crc		(rx_crc)
	);

	spi_frame_ctrl frame_i (
		.sys_clk	(sys_clk),
		.sys_rst_n	(sys_rst_n),
		.frame_start	(frame_start),
		.frame_len	(frame_len),
		.data_tx	(data_tx),
		.tx_next	(tx_next),
		.busy		(busy),
		.rx_valid	(rx_valid),
		.rx_data	(rx_data),
		.status		(status),
		.cs_ctrl	(cs_ctrl),
		.wr_req		(wr_req),
		.byte_out	(byte_out),
		.wr_ack		(wr_ack),
		.data_rx	(data_rx),
		.crc_clr	(crc_clr),
		.tx_crc_upd	(tx_crc_upd),
		.rx_crc_upd	(rx_crc_upd),
		.tx_crc		(tx_crc),
		.rx_crc		(rx_crc)
	);

endmodule

/* design/spi_frame_ctrl.sv */
// spi frame sequencer
// holds cs low for a frame, feeds payload then tx crc to the bit engine,
// forwards received payload and checks the slave crc at frame end
`timescale 1ns/1ps

module spi_frame_ctrl (
	input  logic			sys_clk,
	input  logic			sys_rst_n,
	input  logic			frame_start,		// honoured while busy low
	input  spi_pkg::len_t		frame_len,
	input  spi_pkg::byte_t		data_tx,
	output logic			tx_next,		// data_tx taken
	output logic			busy,
	output logic			rx_valid,
	output spi_pkg::byte_t		rx_data,
	output spi_pkg::frame_status_t	status,
	output logic			cs_ctrl,
	output logic			wr_req,
	output spi_pkg::byte_t		byte_out,
	input  logic			wr_ack,
	input  spi_pkg::byte_t		data_rx,
	output logic			crc_clr,
	output logic			tx_crc_upd,
	output logic			rx_crc_upd,
	input  spi_pkg::byte_t		tx_crc,
	input  spi_pkg::byte_t		rx_crc
);
	import spi_pkg::*;

	frame_state_t		state;
	len_t			len_q;			// payload length of this frame
	len_t			byte_cnt;		// payload bytes done
	logic			is_payload;		// current byte is not the crc
	logic			accept;

	assign accept		= (state == FS_IDLE) && frame_start && !busy;
	assign is_payload	= (byte_cnt != len_q);

	assign wr_req		= (state == FS_ISSUE);	// master is idle here
	assign byte_out		= is_payload ? data_tx : tx_crc;
	assign tx_crc_upd	= wr_req && is_payload;
	assign tx_next		= tx_crc_upd;		// host moves to next byte

	assign crc_clr		= accept;		// one cycle ahead of first upd
	assign rx_data		= data_rx;		// stable from the cycle after wr_ack
	assign rx_crc_upd	= rx_valid;

	// frame sequence
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state		<= FS_IDLE;
			len_q		<= '0;
			byte_cnt	<= '0;
			cs_ctrl		<= 1'b1;
			rx_valid	<= 1'b0;
			status.done	<= 1'b0;
			status.crc_ok	<= 1'b0;
		end else begin
			rx_valid	<= 1'b0;
			status.done	<= 1'b0;
			case (state)
				FS_IDLE: begin
					if (accept) begin
						len_q		<= frame_len;
						byte_cnt	<= '0;
						cs_ctrl		<= 1'b0;	// select for the frame
						state		<= FS_ISSUE;
					end
				end
				FS_ISSUE: begin
					state <= FS_WAIT;
				end
				FS_WAIT: begin
					if (wr_ack) begin
						rx_valid	<= is_payload;	// crc byte not shown
						state		<= FS_FINISH;
					end
				end
				default: begin
					if (is_payload) begin
						byte_cnt	<= byte_cnt + 4'd1;
						state		<= FS_ISSUE;	// master idle next cycle
					end else begin
						status.done	<= 1'b1;
						status.crc_ok	<= (data_rx == rx_crc);
						cs_ctrl		<= 1'b1;	// release with done
						state		<= FS_IDLE;
					end
				end
			endcase
		end
	end

	// busy spans accept to the cycle after done
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (status.done)
			busy <= 1'b0;
	end

endmodule

/* design/spi_crc8.sv */
// running crc-8 register
// folds one byte per upd strobe, msb first, init 0, no final xor
`timescale 1ns/1ps

module spi_crc8 (
	input  logic			sys_clk,
	input  logic			sys_rst_n,
	input  logic			clr,			// back to zero
	input  logic			upd,			// fold data in
	input  spi_pkg::byte_t		data,
	output spi_pkg::byte_t		crc			// valid the cycle after upd
);
	import spi_pkg::*;

	byte_t		crc_next;

	// one byte through the lfsr, eight bit steps
	function automatic byte_t crc8_byte(input byte_t crc_in, input byte_t din);
		byte_t	c;
		c = crc_in ^ din;
		for (int i = 0; i < 8; i++) begin
			if (c[7])
				c = {c[6:0], 1'b0} ^ CRC_POLY;
			else
				c = {c[6:0], 1'b0};
		end
		return c;
	endfunction

	assign crc_next = crc8_byte(crc, data);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			crc <= '0;
		else if (clr)
			crc <= '0;			// new frame
		else if (upd)
			crc <= crc_next;
	end

endmodule

/* design/spi_master.sv */
// spi bit engine
// moves one byte per wr_req, mosi out msb first and miso in
// sclk half period is clk_div_val+2 cycles, mode from CPOL and CPHA
`timescale 1ns/1ps

module spi_master #(
	parameter logic CPOL = 1'b1,			// sclk idle level
	parameter logic CPHA = 1'b1			// 0 samples leading edge, 1 trailing
) (
	input  logic			sys_clk,
	input  logic			sys_rst_n,
	input  logic			cs_ctrl,		// cs follows this level
	input  spi_pkg::div_t		clk_div_val,
	input  logic			wr_req,			// start one byte, idle only
	input  spi_pkg::byte_t		data_tx,
	output logic			wr_ack,			// byte shifted
	output spi_pkg::byte_t		data_rx,		// valid the cycle after wr_ack
	input  logic			miso,
	output logic			cs,
	output logic			sclk,
	output logic			mosi
);
	import spi_pkg::*;

	typedef enum logic [2:0] {
		M_IDLE,					// wait for wr_req
		M_HALF,					// half period before an edge
		M_EDGE,					// toggle sclk
		M_LAST,					// trailing half after edge 16
		M_ACK,					// wr_ack cycle
		M_FINISH				// one cycle before next accept
	} master_state_t;

	master_state_t		state;
	logic [16:0]		cnt_clk;		// wide enough for div+1
	logic [3:0]		edge_cnt;		// 16 edges per byte
	byte_t			mosi_shift;
	byte_t			miso_shift;
	logic			half_done;
	logic			last_done;
	logic			shift_edge;
	logic			sample_edge;

	assign cs		= cs_ctrl;		// frame controller owns cs
	assign mosi		= mosi_shift[7];	// msb first
	assign wr_ack		= (state == M_ACK);

	assign half_done	= (cnt_clk == {1'b0, clk_div_val});
	assign last_done	= (cnt_clk == ({1'b0, clk_div_val} + 17'd1));	// full half period

	// edge 0 is the leading edge of bit 7
	always_comb begin
		shift_edge	= 1'b0;
		sample_edge	= 1'b0;
		if (state == M_EDGE) begin
			if (CPHA) begin
				shift_edge	= !edge_cnt[0] && (edge_cnt != 4'd0);	// leading, bit 7 preloaded
				sample_edge	= edge_cnt[0];				// trailing
			end else begin
				shift_edge	= edge_cnt[0];				// trailing
				sample_edge	= !edge_cnt[0];				// leading
			end
		end
	end

	// byte sequence
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= M_IDLE;
		end else begin
			case (state)
				M_IDLE: begin
					if (wr_req)
						state <= M_HALF;
				end
				M_HALF: begin
					if (half_done)
						state <= M_EDGE;
				end
				M_EDGE: begin
					if (edge_cnt == 4'd15)
						state <= M_LAST;	// all 16 edges done
					else
						state <= M_HALF;
				end
				M_LAST: begin
					if (last_done)
						state <= M_ACK;
				end
				M_ACK: begin
					state <= M_FINISH;
				end
				default: begin
					state <= M_IDLE;		// finish and any stray code
				end
			endcase
		end
	end

	// half period counter
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk <= '0;
		else if (state == M_HALF || state == M_LAST)
			cnt_clk <= cnt_clk + 17'd1;
		else
			cnt_clk <= '0;			// restart after each edge
	end

	// sclk edge counter
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			edge_cnt <= '0;
		else if (state == M_IDLE)
			edge_cnt <= '0;
		else if (state == M_EDGE)
			edge_cnt <= edge_cnt + 4'd1;
	end

	// sclk parks at CPOL between bytes
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			sclk <= CPOL;
		else if (state == M_IDLE)
			sclk <= CPOL;
		else if (state == M_EDGE)
			sclk <= ~sclk;
	end

	// transmit shifter, reset keeps mosi defined before the first byte
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			mosi_shift <= '0;
		else if (state == M_IDLE && wr_req)
			mosi_shift <= data_tx;			// bit 7 on the line at once
		else if (shift_edge)
			mosi_shift <= {mosi_shift[6:0], 1'b0};
	end

	// receive shifter, eight samples fill it
	always_ff @(posedge sys_clk) begin
		if (sample_edge)
			miso_shift <= {miso_shift[6:0], miso};
	end

	// hand the received byte over with the ack
	always_ff @(posedge sys_clk) begin
		if (state == M_ACK)
			data_rx <= miso_shift;
	end

endmodule

/* design/spi_pkg.sv */
// spi crc link shared types
// widths, bus pin and status structs, controller states and the crc-8 polynomial

package spi_pkg;

	typedef logic [7:0]	byte_t;		// one spi data byte
	typedef logic [15:0]	div_t;		// sclk half period is div+2 sys_clk cycles
	typedef logic [3:0]	len_t;		// payload length, 1 to 15

	// bus outputs toward the slave
	typedef struct packed {
		logic	cs;			// chip select, active low
		logic	sclk;			// serial clock
		logic	mosi;			// master data out
	} spi_pins_t;

	// frame result, valid while done is high
	typedef struct packed {
		logic	done;			// one cycle at frame end
		logic	crc_ok;			// received crc matched
	} frame_status_t;

	localparam byte_t CRC_POLY = 8'h07;	// x^8 + x^2 + x + 1

	// frame sequencer states
	typedef enum logic [1:0] {
		FS_IDLE,			// waiting for frame_start
		FS_ISSUE,			// one cycle wr_req to the master
		FS_WAIT,			// byte on the wire
		FS_FINISH			// gap before the next byte or frame end
	} frame_state_t;

endpackage
